//--- scratch_mem_pkg.sv
package scratch_mem_pkg;

  // Memory geometry.
  localparam int WORD_BYTES = 4;
  localparam int WORD_W     = 8 * WORD_BYTES;
  localparam int MEM_ADDR_W = 10;             // 1024 words.

  // APB address map.
  localparam int APB_ADDR_W = 16;

  // Below this address is the memory window.
  localparam logic [APB_ADDR_W-1:0] REG_BASE = 16'h1000;

  // Register offsets from REG_BASE.
  localparam logic [APB_ADDR_W-1:0] REG_CTRL   = 16'h0000;  // Start and opcode.
  localparam logic [APB_ADDR_W-1:0] REG_SRC    = 16'h0004;
  localparam logic [APB_ADDR_W-1:0] REG_DST    = 16'h0008;
  localparam logic [APB_ADDR_W-1:0] REG_LEN    = 16'h000C;
  localparam logic [APB_ADDR_W-1:0] REG_FILL   = 16'h0010;
  localparam logic [APB_ADDR_W-1:0] REG_STATUS = 16'h0014;  // Busy and done.

  // Copy engine opcodes, codes 2 and 3 are reserved.
  typedef enum logic [1:0] {
    OP_COPY = 2'd0,
    OP_FILL = 2'd1
  } op_e;

endpackage

//--- mem_2rw.sv
`timescale 1ns/1ps

module mem_2rw #(
  parameter int BYTES_PER_LINE = 4,
  parameter int ADDR_WIDTH     = 10
) (
  input  logic                          clk,

  input  logic                          ena_a,
  input  logic [BYTES_PER_LINE-1:0]     wen_a,
  input  logic [ADDR_WIDTH-1:0]         addr_a,
  input  logic [8*BYTES_PER_LINE-1:0]   din_a,
  output logic [8*BYTES_PER_LINE-1:0]   dout_a,

  input  logic                          ena_b,
  input  logic [BYTES_PER_LINE-1:0]     wen_b,
  input  logic [ADDR_WIDTH-1:0]         addr_b,
  input  logic [8*BYTES_PER_LINE-1:0]   din_b,
  output logic [8*BYTES_PER_LINE-1:0]   dout_b
);

  localparam int LINE_W = 8 * BYTES_PER_LINE;
  localparam int DEPTH  = 1 << ADDR_WIDTH;

  logic [LINE_W-1:0] mem [DEPTH];

  // Byte lane writes from both ports.
  always_ff @(posedge clk) begin
    for (int i = 0; i < BYTES_PER_LINE; i++) begin
      if (ena_a && wen_a[i]) mem[addr_a][i*8 +: 8] <= din_a[i*8 +: 8];
      if (ena_b && wen_b[i]) mem[addr_b][i*8 +: 8] <= din_b[i*8 +: 8];
    end
  end

  // Output registers load only on enabled reads.
  always_ff @(posedge clk) begin
    if (ena_a && !(|wen_a)) dout_a <= mem[addr_a];
  end

  always_ff @(posedge clk) begin
    if (ena_b && !(|wen_b)) dout_b <= mem[addr_b];
  end

  // The two ports must never write the same word in one cycle.
  a_no_write_collision: assert property (
    @(posedge clk) !(ena_a && ena_b && (|wen_a) && (|wen_b) && (addr_a == addr_b))
  ) else $error("Both RAM ports write word %0d in the same cycle", addr_a);

endmodule

//--- scratch_apb.sv
`timescale 1ns/1ps

module scratch_apb (
  input  logic                                  clk,
  input  logic                                  rst_n,

  input  logic                                  psel,
  input  logic                                  penable,
  input  logic                                  pwrite,
  input  logic [scratch_mem_pkg::APB_ADDR_W-1:0] paddr,
  input  logic [scratch_mem_pkg::WORD_W-1:0]     pwdata,
  input  logic [scratch_mem_pkg::WORD_BYTES-1:0] pstrb,
  output logic [scratch_mem_pkg::WORD_W-1:0]     prdata,
  output logic                                  pready,
  output logic                                  pslverr,

  output logic                                  ena_a,
  output logic [scratch_mem_pkg::WORD_BYTES-1:0] wen_a,
  output logic [scratch_mem_pkg::MEM_ADDR_W-1:0] addr_a,
  output logic [scratch_mem_pkg::WORD_W-1:0]     din_a,
  input  logic [scratch_mem_pkg::WORD_W-1:0]     dout_a,

  output logic                                  start,
  output scratch_mem_pkg::op_e                  op,
  output logic [scratch_mem_pkg::MEM_ADDR_W-1:0] src,
  output logic [scratch_mem_pkg::MEM_ADDR_W-1:0] dst,
  output logic [scratch_mem_pkg::MEM_ADDR_W:0]   len,
  output logic [scratch_mem_pkg::WORD_W-1:0]     fill_pattern,
  input  logic                                  busy,
  input  logic                                  done
);

  import scratch_mem_pkg::*;

  logic                  access;
  logic                  is_mem;
  logic [APB_ADDR_W-1:0] reg_off;
  logic                  mem_rd;
  logic                  rd_pend;
  logic                  reg_wr;
  logic                  ctrl_wr;
  logic                  op_ok;
  logic                  refuse;
  logic [1:0]            ctrl_op;
  logic [MEM_ADDR_W-1:0] src_q;
  logic [MEM_ADDR_W-1:0] dst_q;
  logic [MEM_ADDR_W:0]   len_q;
  logic [WORD_W-1:0]     fill_q;
  logic [WORD_W-1:0]     reg_rdata;

  assign access  = psel && penable;
  assign is_mem  = paddr < REG_BASE;
  assign reg_off = paddr - REG_BASE;
  assign mem_rd  = access && is_mem && !pwrite;

  // Memory window on port A.
  assign ena_a  = access && is_mem && !rd_pend;   // One RAM cycle per transfer.
  assign wen_a  = (access && is_mem && pwrite) ? pstrb : '0;
  assign addr_a = paddr[MEM_ADDR_W+1:2];
  assign din_a  = pwdata;

  // Window reads wait one cycle for the RAM output register.
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      rd_pend <= 1'b0;
    end else begin
      rd_pend <= mem_rd && !rd_pend;
    end
  end

  assign pready = access && (!mem_rd || rd_pend);

  // Start checks.
  assign reg_wr  = access && pwrite && !is_mem;
  assign ctrl_wr = reg_wr && (reg_off == REG_CTRL);
  assign op_ok   = (pwdata[2:1] == OP_COPY) || (pwdata[2:1] == OP_FILL);
  assign refuse  = ctrl_wr && pwdata[0] && (busy || !op_ok);
  assign pslverr = refuse;
  assign start   = ctrl_wr && pwdata[0] && !refuse;

  // The engine samples op in the start cycle, so pass the new opcode through.
  assign op = start ? op_e'(pwdata[2:1]) : op_e'(ctrl_op);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      ctrl_op <= 2'b00;
      src_q   <= '0;
      dst_q   <= '0;
      len_q   <= '0;
      fill_q  <= '0;
    end else if (reg_wr) begin
      case (reg_off)
        REG_CTRL: if (!refuse) ctrl_op <= pwdata[2:1];  // A refused start changes nothing.
        REG_SRC:  src_q  <= pwdata[MEM_ADDR_W-1:0];
        REG_DST:  dst_q  <= pwdata[MEM_ADDR_W-1:0];
        REG_LEN:  len_q  <= pwdata[MEM_ADDR_W:0];
        REG_FILL: fill_q <= pwdata;
        default: ;
      endcase
    end
  end

  assign src          = src_q;
  assign dst          = dst_q;
  assign len          = len_q;
  assign fill_pattern = fill_q;

  // Register read mux. Unused offsets read zero.
  always_comb begin
    reg_rdata = '0;
    case (reg_off)
      REG_CTRL:   reg_rdata[2:1]            = ctrl_op;
      REG_SRC:    reg_rdata[MEM_ADDR_W-1:0] = src_q;
      REG_DST:    reg_rdata[MEM_ADDR_W-1:0] = dst_q;
      REG_LEN:    reg_rdata[MEM_ADDR_W:0]   = len_q;
      REG_FILL:   reg_rdata                 = fill_q;
      REG_STATUS: reg_rdata[1:0]            = {done, busy};
      default: ;
    endcase
  end

  assign prdata = is_mem ? dout_a : reg_rdata;

  // The engine answers every start with busy or done in the next cycle.
  a_start_answered: assert property (
    @(posedge clk) disable iff (!rst_n) start |=> (busy || done)
  ) else $error("Copy engine did not answer a start with busy or done");

endmodule

//--- copy_engine.sv
`timescale 1ns/1ps

module copy_engine (
  input  logic                                  clk,
  input  logic                                  rst_n,

  input  logic                                  start,
  input  scratch_mem_pkg::op_e                  op,
  input  logic [scratch_mem_pkg::MEM_ADDR_W-1:0] src,
  input  logic [scratch_mem_pkg::MEM_ADDR_W-1:0] dst,
  input  logic [scratch_mem_pkg::MEM_ADDR_W:0]   len,
  input  logic [scratch_mem_pkg::WORD_W-1:0]     fill_pattern,
  output logic                                  busy,
  output logic                                  done,

  output logic                                  ena_b,
  output logic [scratch_mem_pkg::WORD_BYTES-1:0] wen_b,
  output logic [scratch_mem_pkg::MEM_ADDR_W-1:0] addr_b,
  output logic [scratch_mem_pkg::WORD_W-1:0]     din_b,
  input  logic [scratch_mem_pkg::WORD_W-1:0]     dout_b
);

  import scratch_mem_pkg::*;

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_READ,
    ST_WRITE
  } state_e;

  state_e                state;
  op_e                   op_q;
  logic [MEM_ADDR_W:0]   rem;      // Words left to write.
  logic [MEM_ADDR_W-1:0] rd_ptr;
  logic [MEM_ADDR_W-1:0] wr_ptr;
  logic [WORD_W-1:0]     fill_q;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state  <= ST_IDLE;
      op_q   <= OP_COPY;
      rem    <= '0;
      rd_ptr <= '0;
      wr_ptr <= '0;
      done   <= 1'b0;
    end else begin
      case (state)
        ST_IDLE: begin
          if (start) begin
            op_q   <= op;
            rem    <= len;
            rd_ptr <= src;
            wr_ptr <= dst;
            if (len == '0) begin
              done <= 1'b1;                 // Nothing to move.
            end else begin
              done  <= 1'b0;
              state <= (op == OP_FILL) ? ST_WRITE : ST_READ;
            end
          end
        end

        ST_READ: begin
          rd_ptr <= rd_ptr + 1'b1;          // Wraps modulo the memory size.
          state  <= ST_WRITE;
        end

        ST_WRITE: begin
          wr_ptr <= wr_ptr + 1'b1;
          rem    <= rem - 1'b1;
          if (rem == 1) begin
            state <= ST_IDLE;
            done  <= 1'b1;
          end else if (op_q == OP_COPY) begin
            state <= ST_READ;
          end
        end

        default: state <= ST_IDLE;
      endcase
    end
  end

  // Pattern is latched with the rest of the setup.
  always_ff @(posedge clk) begin
    if (start && state == ST_IDLE) fill_q <= fill_pattern;
  end

  assign busy = (state != ST_IDLE);

  // Port B.
  assign ena_b  = busy;
  assign wen_b  = (state == ST_WRITE) ? '1 : '0;
  assign addr_b = (state == ST_READ) ? rd_ptr : wr_ptr;
  assign din_b  = (op_q == OP_FILL) ? fill_q : dout_b;  // COPY forwards the word just read.

  a_done_not_busy: assert property (
    @(posedge clk) disable iff (!rst_n) !(busy && done)
  ) else $error("Copy engine reports done while busy");

endmodule

//--- scratch_mem_top.sv
`timescale 1ns/1ps

module scratch_mem_top (
  input  logic                                  clk,
  input  logic                                  rst_n,

  input  logic                                  psel,
  input  logic                                  penable,
  input  logic                                  pwrite,
  input  logic [scratch_mem_pkg::APB_ADDR_W-1:0] paddr,
  input  logic [scratch_mem_pkg::WORD_W-1:0]     pwdata,
  input  logic [scratch_mem_pkg::WORD_BYTES-1:0] pstrb,
  output logic [scratch_mem_pkg::WORD_W-1:0]     prdata,
  output logic                                  pready,
  output logic                                  pslverr
);

  import scratch_mem_pkg::*;

  // Port A, APB window.
  logic                  ena_a;
  logic [WORD_BYTES-1:0] wen_a;
  logic [MEM_ADDR_W-1:0] addr_a;
  logic [WORD_W-1:0]     din_a;
  logic [WORD_W-1:0]     dout_a;

  // Port B, copy engine.
  logic                  ena_b;
  logic [WORD_BYTES-1:0] wen_b;
  logic [MEM_ADDR_W-1:0] addr_b;
  logic [WORD_W-1:0]     din_b;
  logic [WORD_W-1:0]     dout_b;

  // Engine setup.
  logic                  start;
  op_e                   op;
  logic [MEM_ADDR_W-1:0] src;
  logic [MEM_ADDR_W-1:0] dst;
  logic [MEM_ADDR_W:0]   len;
  logic [WORD_W-1:0]     fill_pattern;
  logic                  busy;
  logic                  done;

  scratch_apb i_apb (
    .clk          (clk),
    .rst_n        (rst_n),
    .psel         (psel),
    .penable      (penable),
    .pwrite       (pwrite),
    .paddr        (paddr),
    .pwdata       (pwdata),
    .pstrb        (pstrb),
    .prdata       (prdata),
    .pready       (pready),
    .pslverr      (pslverr),
    .ena_a        (ena_a),
    .wen_a        (wen_a),
    .addr_a       (addr_a),
    .din_a        (din_a),
    .dout_a       (dout_a),
    .start        (start),
    .op           (op),
    .src          (src),
    .dst          (dst),
    .len          (len),
    .fill_pattern (fill_pattern),
    .busy         (busy),
    .done         (done)
  );

  copy_engine i_engine (
    .clk          (clk),
    .rst_n        (rst_n),
    .start        (start),
    .op           (op),
    .src          (src),
    .dst          (dst),
    .len          (len),
    .fill_pattern (fill_pattern),
    .busy         (busy),
    .done         (done),
    .ena_b        (ena_b),
    .wen_b        (wen_b),
    .addr_b       (addr_b),
    .din_b        (din_b),
    .dout_b       (dout_b)
  );

  mem_2rw #(
    .BYTES_PER_LINE (WORD_BYTES),
    .ADDR_WIDTH     (MEM_ADDR_W)
  ) i_ram (
    .clk    (clk),
    .ena_a  (ena_a),
    .wen_a  (wen_a),
    .addr_a (addr_a),
    .din_a  (din_a),
    .dout_a (dout_a),
    .ena_b  (ena_b),
    .wen_b  (wen_b),
    .addr_b (addr_b),
    .din_b  (din_b),
    .dout_b (dout_b)
  );

endmodule

//--- tb_scratch_mem.sv
`timescale 1ns/1ps

module tb_scratch_mem;

  import scratch_mem_pkg::*;

  localparam int APB_TIMEOUT = 16;    // Cycles per transfer.
  localparam int POLL_LIMIT  = 1000;  // STATUS reads per engine run.
  localparam int NUM_WORDS   = 1024;
  localparam logic [31:0] SEED = 32'd57;

  // Step kinds of the stimulus table.
  localparam logic [1:0] K_WR    = 2'd0;
  localparam logic [1:0] K_RD    = 2'd1;
  localparam logic [1:0] K_POLL  = 2'd2;
  localparam logic [1:0] K_RANGE = 2'd3;  // addr is first word, data is word count.

  typedef struct packed {
    logic [1:0]  kind;
    logic [15:0] addr;
    logic [31:0] data;
    logic [3:0]  strb;
    logic        err;
  } step_t;

  logic        clk;
  logic        rst_n;
  logic        psel;
  logic        penable;
  logic        pwrite;
  logic [15:0] paddr;
  logic [31:0] pwdata;
  logic [3:0]  pstrb;
  logic [31:0] prdata;
  logic        pready;
  logic        pslverr;

  step_t       steps[$];
  logic [31:0] shadow [NUM_WORDS];
  logic [9:0]  m_src;
  logic [9:0]  m_dst;
  logic [10:0] m_len;
  logic [31:0] m_fill;
  logic [1:0]  m_status;
  logic [31:0] lfsr_q;
  int          spread [32];
  int          n_checks;
  int          n_errors;
  int          n_timeouts;

  scratch_mem_top i_dut (
    .clk     (clk),
    .rst_n   (rst_n),
    .psel    (psel),
    .penable (penable),
    .pwrite  (pwrite),
    .paddr   (paddr),
    .pwdata  (pwdata),
    .pstrb   (pstrb),
    .prdata  (prdata),
    .pready  (pready),
    .pslverr (pslverr)
  );

  always #4 clk = ~clk;

  // Galois LFSR stepped once for each bit taken.
  function automatic logic [31:0] rand_bits(input int nbits);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < nbits; i++) begin
      lfsr_q = lfsr_q[0] ? ((lfsr_q >> 1) ^ 32'h8020_0003) : (lfsr_q >> 1);
      r = {r[30:0], lfsr_q[0]};
    end
    return r;
  endfunction

  task automatic check(input logic [31:0] actual, input logic [31:0] expected,
                       input string what);
    n_checks++;
    if (actual !== expected) begin
      n_errors++;
      $display("Mismatch at %0t ns: %s, got %h, expected %h", $time, what, actual, expected);
    end
  endtask

  // Engine model. Words move in ascending order like the hardware.
  task automatic start_model(input logic [1:0] op);
    if (m_len == '0) begin
      m_status = 2'b10;
    end else begin
      m_status = 2'b01;
      for (int i = 0; i < int'(m_len); i++) begin
        if (op == OP_FILL) shadow[(int'(m_dst) + i) % NUM_WORDS] = m_fill;
        else shadow[(int'(m_dst) + i) % NUM_WORDS] = shadow[(int'(m_src) + i) % NUM_WORDS];
      end
    end
  endtask

  task automatic model_write(input logic [15:0] addr, input logic [31:0] data,
                             input logic [3:0] strb);
    if (addr < REG_BASE) begin
      for (int b = 0; b < 4; b++)
        if (strb[b]) shadow[addr[11:2]][b*8 +: 8] = data[b*8 +: 8];
    end else begin
      case (addr - REG_BASE)
        REG_CTRL: if (data[0]) start_model(data[2:1]);
        REG_SRC:  m_src  = data[9:0];
        REG_DST:  m_dst  = data[9:0];
        REG_LEN:  m_len  = data[10:0];
        REG_FILL: m_fill = data;
        default: ;
      endcase
    end
  endtask

  function automatic logic [31:0] exp_read(input logic [15:0] addr);
    if (addr < REG_BASE) return shadow[addr[11:2]];
    case (addr - REG_BASE)
      REG_SRC:    return {22'd0, m_src};
      REG_DST:    return {22'd0, m_dst};
      REG_LEN:    return {21'd0, m_len};
      REG_FILL:   return m_fill;
      REG_STATUS: return {30'd0, m_status};
      default:    return '0;
    endcase
  endfunction

  // One APB transfer. Outputs are sampled mid low phase.
  task automatic apb_xfer(input logic wr, input logic [15:0] addr, input logic [31:0] wdata,
                          input logic [3:0] strb, output logic [31:0] rdata, output logic err);
    int   waits;
    logic got;
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = wr;
    paddr   = addr;
    pwdata  = wdata;
    pstrb   = strb;
    @(negedge clk);
    penable = 1'b1;
    waits   = 0;
    got     = 1'b0;
    rdata   = '0;
    err     = 1'b0;
    while (!got && waits < APB_TIMEOUT) begin
      #2;
      if (pready) begin
        got   = 1'b1;
        rdata = prdata;
        err   = pslverr;
      end
      @(negedge clk);
      waits++;
    end
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
    if (!got) begin
      n_timeouts++;
      $display("Timeout: no pready on APB %s to address %h", wr ? "write" : "read", addr);
    end else begin
      // Window reads take two access cycles, everything else one.
      check(32'(waits), (!wr && addr < REG_BASE) ? 32'd2 : 32'd1,
            $sformatf("access cycles of transfer to %h", addr));
    end
  endtask

  task automatic apb_write(input logic [15:0] addr, input logic [31:0] data,
                           input logic [3:0] strb, input logic exp_err);
    logic [31:0] rd;
    logic        err;
    apb_xfer(1'b1, addr, data, strb, rd, err);
    check({31'd0, err}, {31'd0, exp_err}, $sformatf("pslverr of write to %h", addr));
    if (!exp_err) model_write(addr, data, strb);
  endtask

  task automatic apb_read_check(input logic [15:0] addr);
    logic [31:0] rd;
    logic        err;
    apb_xfer(1'b0, addr, 32'd0, 4'd0, rd, err);
    check(rd, exp_read(addr), $sformatf("read of %h", addr));
    check({31'd0, err}, 32'd0, $sformatf("pslverr of read from %h", addr));
  endtask

  task automatic poll_done();
    logic [31:0] rd;
    logic        err;
    logic        seen;
    int          polls;
    seen  = 1'b0;
    polls = 0;
    while (!seen && polls < POLL_LIMIT) begin
      apb_xfer(1'b0, REG_BASE + REG_STATUS, 32'd0, 4'd0, rd, err);
      seen = rd[1];
      polls++;
    end
    if (!seen) begin
      n_timeouts++;
      $display("Timeout: copy engine did not report done after %0d status reads", polls);
    end
    m_status = 2'b10;
  endtask

  task automatic add_step(input logic [1:0] kind, input logic [15:0] addr,
                          input logic [31:0] data, input logic [3:0] strb, input logic err);
    steps.push_back('{kind: kind, addr: addr, data: data, strb: strb, err: err});
  endtask

  task automatic build_table();
    // Register reads return values masked to their field widths.
    add_step(K_RD, REG_BASE + REG_STATUS, 0, 0, 0);
    add_step(K_WR, REG_BASE + REG_SRC, 32'hFFFF_FFFF, 4'hF, 0);
    add_step(K_RD, REG_BASE + REG_SRC, 0, 0, 0);
    add_step(K_WR, REG_BASE + REG_DST, 32'hFFFF_F555, 4'hF, 0);
    add_step(K_RD, REG_BASE + REG_DST, 0, 0, 0);
    add_step(K_WR, REG_BASE + REG_LEN, 32'hFFFF_FFFF, 4'hF, 0);
    add_step(K_RD, REG_BASE + REG_LEN, 0, 0, 0);
    add_step(K_WR, REG_BASE + REG_FILL, 32'hA5C3_1E77, 4'hF, 0);
    add_step(K_RD, REG_BASE + REG_FILL, 0, 0, 0);
    add_step(K_WR, REG_BASE + 16'h0018, 32'h1234_5678, 4'hF, 0);
    add_step(K_RD, REG_BASE + 16'h0018, 0, 0, 0);
    add_step(K_RD, 16'h2000, 0, 0, 0);
    add_step(K_RD, 16'hFFFC, 0, 0, 0);
    // Zero length is done at once, while done is still low from reset.
    add_step(K_WR, REG_BASE + REG_DST, 50, 4'hF, 0);
    add_step(K_WR, REG_BASE + REG_LEN, 0, 4'hF, 0);
    add_step(K_WR, REG_BASE + REG_CTRL, 32'h1, 4'hF, 0);
    add_step(K_RD, REG_BASE + REG_STATUS, 0, 0, 0);
    add_step(K_POLL, 0, 0, 0, 0);
    add_step(K_RANGE, 48, 6, 0, 0);
    // FILL of 20 words from 100.
    add_step(K_WR, REG_BASE + REG_DST, 100, 4'hF, 0);
    add_step(K_WR, REG_BASE + REG_LEN, 20, 4'hF, 0);
    add_step(K_WR, REG_BASE + REG_FILL, 32'hDEAD_BEEF, 4'hF, 0);
    add_step(K_WR, REG_BASE + REG_CTRL, 32'h3, 4'hF, 0);
    add_step(K_POLL, 0, 0, 0, 0);
    add_step(K_RANGE, 99, 22, 0, 0);
    // COPY without overlap, with DST = SRC + 1, and across the wrap.
    add_step(K_WR, REG_BASE + REG_SRC, 200, 4'hF, 0);
    add_step(K_WR, REG_BASE + REG_DST, 500, 4'hF, 0);
    add_step(K_WR, REG_BASE + REG_LEN, 40, 4'hF, 0);
    add_step(K_WR, REG_BASE + REG_CTRL, 32'h1, 4'hF, 0);
    add_step(K_POLL, 0, 0, 0, 0);
    add_step(K_RANGE, 499, 42, 0, 0);
    add_step(K_WR, REG_BASE + REG_SRC, 600, 4'hF, 0);
    add_step(K_WR, REG_BASE + REG_DST, 601, 4'hF, 0);
    add_step(K_WR, REG_BASE + REG_LEN, 16, 4'hF, 0);
    add_step(K_WR, REG_BASE + REG_CTRL, 32'h1, 4'hF, 0);
    add_step(K_POLL, 0, 0, 0, 0);
    add_step(K_RANGE, 599, 20, 0, 0);
    add_step(K_WR, REG_BASE + REG_SRC, 1016, 4'hF, 0);
    add_step(K_WR, REG_BASE + REG_DST, 4, 4'hF, 0);
    add_step(K_WR, REG_BASE + REG_LEN, 12, 4'hF, 0);
    add_step(K_WR, REG_BASE + REG_CTRL, 32'h1, 4'hF, 0);
    add_step(K_POLL, 0, 0, 0, 0);
    add_step(K_RANGE, 1014, 27, 0, 0);
    // Refused starts during a long FILL and with a reserved opcode.
    add_step(K_WR, REG_BASE + REG_DST, 700, 4'hF, 0);
    add_step(K_WR, REG_BASE + REG_LEN, 200, 4'hF, 0);
    add_step(K_WR, REG_BASE + REG_FILL, 32'h1357_2468, 4'hF, 0);
    add_step(K_WR, REG_BASE + REG_CTRL, 32'h3, 4'hF, 0);
    add_step(K_RD, REG_BASE + REG_STATUS, 0, 0, 0);
    add_step(K_WR, REG_BASE + REG_CTRL, 32'h1, 4'hF, 1);
    add_step(K_WR, REG_BASE + REG_CTRL, 32'h5, 4'hF, 1);
    add_step(K_POLL, 0, 0, 0, 0);
    add_step(K_RANGE, 699, 202, 0, 0);
    add_step(K_WR, REG_BASE + REG_DST, 300, 4'hF, 0);
    add_step(K_WR, REG_BASE + REG_LEN, 8, 4'hF, 0);
    add_step(K_WR, REG_BASE + REG_CTRL, 32'h7, 4'hF, 1);
    add_step(K_WR, REG_BASE + REG_CTRL, 32'h5, 4'hF, 1);
    add_step(K_RD, REG_BASE + REG_STATUS, 0, 0, 0);
    add_step(K_RANGE, 298, 12, 0, 0);
  endtask

  task automatic run_step(input step_t s);
    case (s.kind)
      K_WR:    apb_write(s.addr, s.data, s.strb, s.err);
      K_RD:    apb_read_check(s.addr);
      K_POLL:  poll_done();
      default: begin
        for (int i = 0; i < int'(s.data); i++)
          apb_read_check(16'(((int'(s.addr) + i) % NUM_WORDS) * 4));
      end
    endcase
  endtask

  initial begin
    clk        = 1'b0;
    rst_n      = 1'b0;
    psel       = 1'b0;
    penable    = 1'b0;
    pwrite     = 1'b0;
    paddr      = '0;
    pwdata     = '0;
    pstrb      = '0;
    lfsr_q     = SEED;
    m_src      = '0;
    m_dst      = '0;
    m_len      = '0;
    m_fill     = '0;
    m_status   = '0;
    n_checks   = 0;
    n_errors   = 0;
    n_timeouts = 0;
    repeat (5) @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);

    // Memory contents are not reset, so give every word a known value.
    for (int w = 0; w < NUM_WORDS; w++) apb_write(16'(w * 4), rand_bits(32), 4'hF, 1'b0);

    for (int i = 0; i < 32; i++) begin
      spread[i] = i * 32 + int'(rand_bits(5));
      apb_write(16'(spread[i] * 4), rand_bits(32), 4'hF, 1'b0);
    end
    for (int pass = 0; pass < 2; pass++)
      for (int i = 0; i < 32; i++) apb_read_check(16'(spread[i] * 4));

    // Every strobe pattern including zero.
    for (int s = 0; s < 16; s++) begin
      apb_write(16'(((s * 61 + 7) % NUM_WORDS) * 4), rand_bits(32), 4'(s), 1'b0);
      apb_read_check(16'(((s * 61 + 7) % NUM_WORDS) * 4));
    end

    build_table();
    foreach (steps[n]) run_step(steps[n]);

    $display("Checks: %0d, mismatches: %0d, timeouts: %0d", n_checks, n_errors, n_timeouts);
    if (n_errors == 0 && n_timeouts == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

//--- scratch_mem.f
scratch_mem_pkg.sv
mem_2rw.sv
scratch_apb.sv
copy_engine.sv
scratch_mem_top.sv
tb_scratch_mem.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Builds and runs the scratch_mem testbench with Verilator.
set -u
cd "$(dirname "$0")" || exit 1

rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_scratch_mem --Mdir obj_dir \
  -f scratch_mem.f \
  || { echo "Verilator build failed"; exit 1; }

./obj_dir/Vtb_scratch_mem 2>&1 | tee sim.log

grep -q "Regression failed" sim.log && { echo "Simulation FAILED"; exit 1; }
grep -q "Regression passed" sim.log || { echo "Simulation ended without a result"; exit 1; }
echo "Simulation PASSED"
exit 0
